// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_camera_capture
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SOURCES   := $(wildcard hdl/*.sv tb/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/cam_bus_pkg.sv
`default_nettype none

// camera side definitions: parallel bus byte, pixel format, frame counters
package cam_bus_pkg;

  // flops per synchronizer chain on the asynchronous camera pins
  localparam int SYNC_STAGES = 2;

  typedef logic [7:0] cam_byte_t;  // one byte on the camera data bus

  // rgb565 pixel
  // [15:11] red, [10:5] green, [4:0] blue
  typedef logic [15:0] pixel_t;

  typedef logic [10:0] hcount_t;  // pixel index inside a line
  typedef logic [9:0] vcount_t;  // line index inside a frame

endpackage

`default_nettype wire

// File: hdl/cam_pixel_decoder.sv
`default_nettype none

// samples the parallel camera bus in the clk_camera domain
// two bytes per pixel, high byte first, taken on pclk rising edges while hsync is high
module cam_pixel_decoder
  import cam_bus_pkg::*;
#(
  parameter int FRAME_WIDTH  = 1280,  // pixels per line
  parameter int FRAME_HEIGHT = 720    // lines per frame
) (
  input  wire            clk_camera,
  input  wire            recent_reset,
  input  wire cam_byte_t cam_data_i,   // async camera pins
  input  wire            cam_pclk_i,
  input  wire            cam_hsync_i,
  input  wire            cam_vsync_i,
  output logic           pix_valid_o,  // one cycle strobe per pixel
  output pixel_t         pix_data_o,
  output logic           pix_last_o,   // last pixel of the frame
  output logic           line_end_o,   // hsync falling edge
  output hcount_t        line_len_o,   // pixels in the line that just ended
  output logic           frame_end_o   // vsync rising edge
);

  // index 0 sits next to the pin
  logic [SYNC_STAGES-1:0] pclk_sync, hsync_sync, vsync_sync;
  cam_byte_t              data_sync [SYNC_STAGES];

  logic      pclk_s, hsync_s, vsync_s;  // synchronized copies
  cam_byte_t data_s;
  logic      pclk_q, hsync_q, vsync_q;  // one cycle older, for edges
  logic      pclk_rise, hsync_fall, vsync_rise;

  logic      byte_phase;  // high byte already captured
  cam_byte_t hi_byte;
  hcount_t   hcount;      // pixels seen so far in this line
  vcount_t   vcount;      // lines finished so far in this frame

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      pclk_sync  <= '0;
      hsync_sync <= '0;
      vsync_sync <= '0;
    end else begin
      pclk_sync  <= {pclk_sync[SYNC_STAGES-2:0], cam_pclk_i};
      hsync_sync <= {hsync_sync[SYNC_STAGES-2:0], cam_hsync_i};
      vsync_sync <= {vsync_sync[SYNC_STAGES-2:0], cam_vsync_i};
    end
  end

  // data chain has the same depth, so data_s lines up with pclk_s
  always_ff @(posedge clk_camera) begin
    data_sync[0] <= cam_data_i;
    for (int i = 1; i < SYNC_STAGES; i++) begin
      data_sync[i] <= data_sync[i-1];
    end
  end

  assign pclk_s  = pclk_sync[SYNC_STAGES-1];
  assign hsync_s = hsync_sync[SYNC_STAGES-1];
  assign vsync_s = vsync_sync[SYNC_STAGES-1];
  assign data_s  = data_sync[SYNC_STAGES-1];

  assign pclk_rise  = pclk_s & ~pclk_q;
  assign hsync_fall = ~hsync_s & hsync_q;  // line gap begins
  assign vsync_rise = vsync_s & ~vsync_q;  // frame gap begins

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      pclk_q      <= 1'b0;
      hsync_q     <= 1'b0;
      vsync_q     <= 1'b0;
      byte_phase  <= 1'b0;
      hcount      <= '0;
      vcount      <= '0;
      pix_valid_o <= 1'b0;
      pix_last_o  <= 1'b0;
      line_end_o  <= 1'b0;
      frame_end_o <= 1'b0;
    end else begin
      pclk_q      <= pclk_s;
      hsync_q     <= hsync_s;
      vsync_q     <= vsync_s;
      pix_valid_o <= 1'b0;
      pix_last_o  <= 1'b0;
      line_end_o  <= hsync_fall;
      frame_end_o <= vsync_rise;
      if (vsync_s) vcount <= '0;  // held at zero through the frame gap
      else if (hsync_fall) vcount <= vcount + 1'b1;
      if (hsync_fall) begin
        hcount     <= '0;
        byte_phase <= 1'b0;  // a stray odd byte does not leak into the next line
      end else if (pclk_rise && hsync_s) begin
        byte_phase <= ~byte_phase;
        if (byte_phase) begin  // low byte, pixel complete
          pix_valid_o <= 1'b1;
          pix_last_o  <= (hcount == hcount_t'(FRAME_WIDTH - 1)) &&
                         (vcount == vcount_t'(FRAME_HEIGHT - 1));
          hcount      <= hcount + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_camera) begin
    if (pclk_rise && hsync_s) begin
      if (!byte_phase) hi_byte <= data_s;
      else pix_data_o <= {hi_byte, data_s};
    end
    if (hsync_fall) line_len_o <= hcount;
  end

  // pclk is at most a quarter of clk_camera, and pixels need two pclk edges
  a_pix_valid_single : assert property (
    @(posedge clk_camera) disable iff (recent_reset) pix_valid_o |=> !pix_valid_o
  );

endmodule

`default_nettype wire

// File: hdl/camera_capture_top.sv
`default_nettype none

// camera capture front end: pins -> pixels -> 128 bit chunks, plus frame check
module camera_capture_top
  import cam_bus_pkg::*;
  import chunk_stream_pkg::*;
#(
  parameter int FRAME_WIDTH  = 1280,
  parameter int FRAME_HEIGHT = 720
) (
  input  wire            clk_camera,
  input  wire            recent_reset,
  input  wire cam_byte_t cam_data_i,
  input  wire            cam_pclk_i,
  input  wire            cam_hsync_i,
  input  wire            cam_vsync_i,
  output logic           chunk_tvalid_o,
  input  wire            chunk_tready_i,
  output chunk_t         chunk_tdata_o,
  output logic           chunk_tlast_o,
  output logic           overflow_o,
  output logic           frame_ok_o,
  output logic           frame_bad_o
);

  logic    pix_valid, pix_last;  // decoder -> stacker
  pixel_t  pix_data;
  logic    line_end, frame_end;  // decoder -> checker
  hcount_t line_len;

  cam_pixel_decoder #(
    .FRAME_WIDTH (FRAME_WIDTH),
    .FRAME_HEIGHT(FRAME_HEIGHT)
  ) i_cam_pixel_decoder (
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .cam_data_i  (cam_data_i),
    .cam_pclk_i  (cam_pclk_i),
    .cam_hsync_i (cam_hsync_i),
    .cam_vsync_i (cam_vsync_i),
    .pix_valid_o (pix_valid),
    .pix_data_o  (pix_data),
    .pix_last_o  (pix_last),
    .line_end_o  (line_end),
    .line_len_o  (line_len),
    .frame_end_o (frame_end)
  );

  pixel_stacker i_pixel_stacker (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .pix_valid_i   (pix_valid),
    .pix_data_i    (pix_data),
    .pix_last_i    (pix_last),
    .chunk_tready_i(chunk_tready_i),
    .chunk_tvalid_o(chunk_tvalid_o),
    .chunk_tdata_o (chunk_tdata_o),
    .chunk_tlast_o (chunk_tlast_o),
    .overflow_o    (overflow_o)
  );

  frame_checker #(
    .FRAME_WIDTH (FRAME_WIDTH),
    .FRAME_HEIGHT(FRAME_HEIGHT)
  ) i_frame_checker (
    .clk_camera  (clk_camera),
    .recent_reset(recent_reset),
    .line_end_i  (line_end),
    .line_len_i  (line_len),
    .frame_end_i (frame_end),
    .frame_ok_o  (frame_ok_o),
    .frame_bad_o (frame_bad_o)
  );

endmodule

`default_nettype wire

// File: hdl/chunk_stream_pkg.sv
`default_nettype none

// chunk stream toward memory, one 128 bit word per eight pixels
package chunk_stream_pkg;
  import cam_bus_pkg::*;

  localparam int PIXELS_PER_CHUNK = 8;

  // pixel k of a chunk lives in bits 16k+15 down to 16k
  typedef logic [PIXELS_PER_CHUNK*$bits(pixel_t)-1:0] chunk_t;

endpackage

`default_nettype wire

// File: hdl/frame_checker.sv
`default_nettype none

// checks each frame for FRAME_HEIGHT lines of FRAME_WIDTH pixels
// one pulse per frame end, ok or bad
module frame_checker
  import cam_bus_pkg::*;
#(
  parameter int FRAME_WIDTH  = 1280,
  parameter int FRAME_HEIGHT = 720
) (
  input  wire          clk_camera,
  input  wire          recent_reset,
  input  wire          line_end_i,
  input  wire hcount_t line_len_i,
  input  wire          frame_end_i,
  output logic         frame_ok_o,
  output logic         frame_bad_o
);

  vcount_t line_cnt;   // lines ended in this frame
  vcount_t lines_now;  // including a line end on this very cycle
  logic    line_err;   // some line had a wrong length or came before sync
  logic    started;    // a frame boundary was seen since reset
  logic    len_bad;

  assign len_bad   = line_end_i && (line_len_i != hcount_t'(FRAME_WIDTH));
  assign lines_now = line_cnt + vcount_t'(line_end_i);  // last hsync may meet vsync

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      line_cnt    <= '0;
      line_err    <= 1'b0;
      started     <= 1'b0;
      frame_ok_o  <= 1'b0;
      frame_bad_o <= 1'b0;
    end else begin
      frame_ok_o  <= 1'b0;
      frame_bad_o <= 1'b0;
      if (frame_end_i) begin
        if (started && !line_err && !len_bad &&
            lines_now == vcount_t'(FRAME_HEIGHT)) frame_ok_o <= 1'b1;
        else frame_bad_o <= 1'b1;  // also the partial frame after reset
        started  <= 1'b1;
        line_cnt <= '0;
        line_err <= 1'b0;
      end else if (line_end_i) begin
        line_cnt <= line_cnt + 1'b1;
        if (len_bad || !started) line_err <= 1'b1;
      end
    end
  end

  // exactly one verdict, and only right after a frame end
  a_one_verdict : assert property (
    @(posedge clk_camera) disable iff (recent_reset)
      (frame_ok_o || frame_bad_o) |-> !(frame_ok_o && frame_bad_o) && $past(frame_end_i)
  );

endmodule

`default_nettype wire

// File: hdl/pixel_stacker.sv
`default_nettype none

// packs PIXELS_PER_CHUNK pixels into one chunk on a valid/ready stream
// one accumulator plus one output register, no ready toward the decoder
module pixel_stacker
  import cam_bus_pkg::*;
  import chunk_stream_pkg::*;
(
  input  wire         clk_camera,
  input  wire         recent_reset,
  input  wire         pix_valid_i,
  input  wire pixel_t pix_data_i,
  input  wire         pix_last_i,      // pixel closes the frame
  input  wire         chunk_tready_i,
  output logic        chunk_tvalid_o,
  output chunk_t      chunk_tdata_o,
  output logic        chunk_tlast_o,
  output logic        overflow_o       // sticky until reset
);

  localparam int PIXEL_BITS = $bits(pixel_t);
  localparam int SLOT_W     = $clog2(PIXELS_PER_CHUNK);

  chunk_t            acc;         // chunk under construction
  chunk_t            merged;      // acc with the incoming pixel in place
  logic [SLOT_W-1:0] slot;        // next free pixel position
  logic              chunk_done;  // incoming pixel fills the last slot
  logic              out_free;    // output register can take a chunk this cycle

  always_comb begin
    merged = acc;
    merged[slot*PIXEL_BITS +: PIXEL_BITS] = pix_data_i;
  end

  assign chunk_done = pix_valid_i && (slot == SLOT_W'(PIXELS_PER_CHUNK - 1));
  // empty, or emptied by a transfer on this same edge
  assign out_free   = !chunk_tvalid_o || chunk_tready_i;

  always_ff @(posedge clk_camera) begin
    if (recent_reset) begin
      slot           <= '0;
      chunk_tvalid_o <= 1'b0;
      overflow_o     <= 1'b0;
    end else begin
      if (pix_valid_i) begin
        // frame end realigns the slots even when the chunk gets dropped
        if (chunk_done || pix_last_i) slot <= '0;
        else slot <= slot + 1'b1;
      end
      if (chunk_done && out_free) chunk_tvalid_o <= 1'b1;
      else if (chunk_tready_i) chunk_tvalid_o <= 1'b0;  // taken, nothing new
      if (chunk_done && !out_free) overflow_o <= 1'b1;  // chunk lost
    end
  end

  // payload path
  always_ff @(posedge clk_camera) begin
    if (pix_valid_i) acc <= merged;
    if (chunk_done && out_free) begin
      chunk_tdata_o <= merged;      // valid rises one cycle after the eighth pixel
      chunk_tlast_o <= pix_last_i;
    end
  end

  // held chunk must not change until the sink takes it
  a_chunk_stable : assert property (
    @(posedge clk_camera) disable iff (recent_reset)
      chunk_tvalid_o && !chunk_tready_i |=>
        chunk_tvalid_o && $stable(chunk_tdata_o) && $stable(chunk_tlast_o)
  );

endmodule

`default_nettype wire

// File: src.f
+incdir+include
hdl/cam_bus_pkg.sv
hdl/chunk_stream_pkg.sv
hdl/cam_pixel_decoder.sv
hdl/pixel_stacker.sv
hdl/frame_checker.sv
hdl/camera_capture_top.sv
tb/tb_camera_capture.sv

// File: include/tb_sensor_tasks.svh
`ifndef TB_SENSOR_TASKS_SVH
`define TB_SENSOR_TASKS_SVH

// camera sensor side of the bench
// pins change 1 unit after a clk_camera edge, half is the pclk half period in clocks

task automatic put_byte(input logic [7:0] b, input int half);
  cam_data = b;       // sensor changes data while pclk is low
  tick(half);
  cam_pclk = 1'b1;    // byte sampled on this rising edge
  tick(half);
  cam_pclk = 1'b0;
endtask

// one line of random pixels, high byte first, then a random line gap
task automatic send_line(input int npix, input int half);
  logic [15:0] px;
  cam_hsync = 1'b1;
  m_h = 0;
  for (int i = 0; i < npix; i++) begin
    px = 16'($urandom);
    put_byte(px[15:8], half);
    put_byte(px[7:0], half);
    model_pixel(px);
  end
  tick(half);
  cam_hsync = 1'b0;  // line gap
  m_v++;
  tick(4 + $urandom_range(12));
endtask

// nlines lines, line short_at is two pixels short, closed by a vsync gap
task automatic send_frame(input int nlines, input int short_at);
  int half;
  half = 2 + $urandom_range(2);
  cam_vsync = 1'b0;
  m_v = 0;
  tick(6 + $urandom_range(10));
  for (int l = 0; l < nlines; l++) send_line((l == short_at) ? WIDTH - 2 : WIDTH, half);
  cam_vsync = 1'b1;  // frame gap, checker verdict follows
  tick(8 + $urandom_range(16));
endtask

`endif

// File: tb/tb_camera_capture.sv
`default_nettype none

// random camera frames in, chunks checked against a pixel packing model
module tb_camera_capture;
  localparam int WIDTH   = 16;
  localparam int HEIGHT  = 4;
  localparam int TIMEOUT = 3000;  // clocks per wait loop

  logic         clk_camera, recent_reset;
  logic [7:0]   cam_data;
  logic         cam_pclk, cam_hsync, cam_vsync;
  logic         chunk_tvalid, chunk_tready, chunk_tlast;
  logic         overflow, frame_ok, frame_bad;
  logic [127:0] chunk_tdata;

  logic [128:0] exp_q[$];  // {last, data} of chunks still expected
  logic [127:0] m_acc;     // model accumulator
  logic [127:0] held_data;
  logic         held_last;
  logic         held;      // chunk offered but not taken last edge
  bit           hold_ready;
  int           m_slot, m_h, m_v, low_run;
  int           errors, n_ok, n_bad, n_last, n_chunks;

  camera_capture_top #(.FRAME_WIDTH(WIDTH), .FRAME_HEIGHT(HEIGHT)) i_camera_capture_top (
    .clk_camera    (clk_camera),
    .recent_reset  (recent_reset),
    .cam_data_i    (cam_data),
    .cam_pclk_i    (cam_pclk),
    .cam_hsync_i   (cam_hsync),
    .cam_vsync_i   (cam_vsync),
    .chunk_tvalid_o(chunk_tvalid),
    .chunk_tready_i(chunk_tready),
    .chunk_tdata_o (chunk_tdata),
    .chunk_tlast_o (chunk_tlast),
    .overflow_o    (overflow),
    .frame_ok_o    (frame_ok),
    .frame_bad_o   (frame_bad)
  );

  initial begin
    clk_camera = 1'b0;
    forever #4 clk_camera = ~clk_camera;
  end

  task automatic tick(input int n);
    repeat (n) @(posedge clk_camera);
    #1;  // drive point after the edge
  endtask

  function automatic void report_mismatch(input string msg);
    $display("mismatch at %0t: %s", $time, msg);
    errors++;
  endfunction

  // packing rule: pixel k in bits 16k+15..16k, frame's last pixel realigns the slots
  function automatic void model_pixel(input logic [15:0] px);
    logic last;
    last = (m_h == WIDTH - 1) && (m_v == HEIGHT - 1);
    m_acc[m_slot*16 +: 16] = px;
    m_h++;
    if (m_slot == 7) exp_q.push_back({last, m_acc});
    m_slot = (m_slot == 7 || last) ? 0 : m_slot + 1;
  endfunction

  function automatic void take_chunk();
    logic [128:0] e;
    n_chunks++;
    if (chunk_tlast) n_last++;
    if (exp_q.size() == 0) begin
      $display("error at %0t: chunk arrived with no pixels left in the model", $time);
      errors++;
    end else begin
      e = exp_q.pop_front();
      if ({chunk_tlast, chunk_tdata} !== e)
        report_mismatch($sformatf("chunk %h last %b, expected %h last %b",
                                  chunk_tdata, chunk_tlast, e[127:0], e[128]));
    end
  endfunction

  `include "tb_sensor_tasks.svh"

  // stream sink and pulse monitor, sampled on the edge
  always @(posedge clk_camera) begin
    if (recent_reset) held = 1'b0;
    else begin
      if (held && (!chunk_tvalid || chunk_tdata !== held_data || chunk_tlast !== held_last))
        report_mismatch("held chunk dropped or changed while ready was low");
      held      = chunk_tvalid && !chunk_tready;
      held_data = chunk_tdata;
      held_last = chunk_tlast;
      if (chunk_tvalid && chunk_tready) take_chunk();
      if (frame_ok) n_ok++;
      if (frame_bad) n_bad++;
    end
  end

  // random ready, low runs capped at 10 unless held
  always @(posedge clk_camera) begin
    #1;
    if (hold_ready || (low_run < 10 && $urandom_range(2) == 0)) begin
      chunk_tready = 1'b0;
      low_run++;
    end else begin
      chunk_tready = 1'b1;
      low_run = 0;
    end
  end

  task automatic apply_reset();
    recent_reset = 1'b1;
    tick(2);
    recent_reset = 1'b0;
    m_slot = 0;
    m_h    = 0;
    m_v    = 0;
    exp_q.delete();  // chunks in flight are gone
  endtask

  task automatic wait_drained();
    int t;
    t = 0;
    while (exp_q.size() != 0 && t < TIMEOUT) begin
      tick(1);
      t++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout at %0t: %0d expected chunks never arrived", $time, exp_q.size());
      errors++;
    end
  endtask

  task automatic wait_verdicts(input int target);
    int t;
    t = 0;
    while (n_ok + n_bad < target && t < TIMEOUT) begin
      tick(1);
      t++;
    end
    if (n_ok + n_bad < target) begin
      $display("timeout at %0t: frame checker gave no verdict", $time);
      errors++;
    end
  endtask

  // first vsync gap after reset closes a partial frame, one bad verdict
  task automatic sync_frame();
    int b0;
    b0 = n_bad;
    tick(4);
    cam_vsync = 1'b1;
    wait_verdicts(n_ok + n_bad + 1);
    if (n_bad != b0 + 1) report_mismatch("partial frame after reset not reported bad");
  endtask

  // behaviors 1 to 3
  task automatic test_good(input int nframes, input string name);
    int ok0, bad0, last0, err0;
    ok0  = n_ok;
    bad0 = n_bad;
    last0 = n_last;
    err0 = errors;
    repeat (nframes) send_frame(HEIGHT, -1);
    wait_drained();
    wait_verdicts(ok0 + bad0 + nframes);
    if (n_last - last0 != nframes)
      report_mismatch($sformatf("%0d last chunks for %0d frames", n_last - last0, nframes));
    if (n_ok - ok0 != nframes || n_bad != bad0)
      report_mismatch($sformatf("%0d ok and %0d bad verdicts", n_ok - ok0, n_bad - bad0));
    $display("test %s: %0d frames, %s", name, nframes, (errors == err0) ? "ok" : "errors");
  endtask

  task automatic test_bad_frames();
    int ok0, bad0, err0;
    ok0  = n_ok;
    bad0 = n_bad;
    err0 = errors;
    send_frame(HEIGHT, 1);  // second line short
    send_frame(3, -1);      // one line missing
    wait_drained();
    wait_verdicts(ok0 + bad0 + 2);
    if (n_bad - bad0 != 2 || n_ok != ok0)
      report_mismatch($sformatf("%0d bad and %0d ok verdicts", n_bad - bad0, n_ok - ok0));
    $display("test bad_frames: %s", (errors == err0) ? "ok" : "errors");
  endtask

  task automatic test_backpressure();
    int v0, err0;
    v0   = n_ok + n_bad;
    err0 = errors;
    hold_ready = 1'b1;
    send_frame(HEIGHT, -1);
    while (exp_q.size() > 1) void'(exp_q.pop_back());  // only the first chunk survives
    if (!chunk_tvalid) report_mismatch("valid fell while ready was held low");
    if (!overflow) report_mismatch("overflow_o low after chunks were lost");
    hold_ready = 1'b0;
    wait_drained();
    wait_verdicts(v0 + 1);
    $display("test backpressure: %s", (errors == err0) ? "ok" : "errors");
  endtask

  task automatic test_reset();
    int err0;
    err0 = errors;
    cam_vsync = 1'b0;
    m_v = 0;
    tick(8);
    send_line(WIDTH, 3);
    send_line(WIDTH, 3);
    cam_hsync = 1'b1;
    put_byte(8'h5a, 3);  // reset lands in mid-line
    put_byte(8'ha5, 3);
    put_byte(8'h3c, 3);
    apply_reset();
    if (chunk_tvalid || overflow || frame_ok || frame_bad)
      report_mismatch("outputs not low right after reset");
    cam_hsync = 1'b0;
    sync_frame();
    $display("test reset_state: %s", (errors == err0) ? "ok" : "errors");
    test_good(1, "after_reset");
  endtask

  initial begin
    void'($urandom(32'hb262923f));
    {cam_data, cam_pclk, cam_hsync, cam_vsync} = '0;
    chunk_tready = 1'b0;
    hold_ready   = 1'b0;
    held         = 1'b0;
    {low_run, errors, n_ok, n_bad, n_last, n_chunks} = '0;
    apply_reset();
    sync_frame();
    test_good(2, "good_frames");
    test_bad_frames();
    test_backpressure();
    test_reset();
    $display("done: %0d chunks, %0d ok frames, %0d bad frames, %0d errors",
             n_chunks, n_ok, n_bad, errors);
    if (errors == 0) $display("sim passed");
    else $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire
